// ==== list.f ====
mmu_pkg.sv
tlb.sv
page_walker.sv
pte_mem.sv
mmu_top.sv
tb_mmu.sv

// ==== Makefile ====
# Verilator flow for the Sv32 mmu testbench

TOP = tb_mmu

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== tb_mmu.sv ====
/*
 * tb_mmu
 * random-stimulus testbench for the Sv32 mmu; a page table image built from
 * an xorshift stream is loaded into the DUT and mirrored by a walk model
 */
`timescale 1ns/1ps

module tb_mmu import mmu_pkg::*; ();

    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT   = 2000;  // cycles per request

    logic               CLK;
    logic               nRST;
    csr_t               csr;
    logic               flush;
    logic [1:0]         req;
    xlat_req_t [1:0]    xreq;
    logic [1:0]         done;
    xlat_rsp_t [1:0]    xrsp;
    logic               ld_en;
    logic [PADDR_W-3:0] ld_addr;
    pte_t               ld_data;

    pte_t        pt_image [MEM_WORDS];  // mirror of the DUT page table
    logic [31:0] rng_state = 32'd57120;
    int          checks    = 0;
    int          errors    = 0;
    logic        hung      = 1'b0;      // set once a port never answered

    mmu_top #(
        .TLB_ENTRIES   (4),
        .PTE_MEM_WORDS (MEM_WORDS),
        .MEM_LATENCY   (2)
    ) mmu_top_inst (
        .CLK     (CLK),
        .nRST    (nRST),
        .csr     (csr),
        .flush   (flush),
        .req     (req),
        .xreq    (xreq),
        .done    (done),
        .xrsp    (xrsp),
        .ld_en   (ld_en),
        .ld_addr (ld_addr),
        .ld_data (ld_data)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // small vpn range so addresses repeat
    function automatic va_t rand_va();
        va_t v;
        v = va_t'(next_rand());
        v.vpn1[9:6] = '0;
        v.vpn0[9:6] = '0;
        return v;
    endfunction

    function automatic pte_t rand_pte();
        logic [31:0] r;
        pte_t        e;
        r = next_rand();
        e = pte_t'(next_rand());
        e.perms.reserved = '0;
        case (r[2:0])
            3'd0: e.perms.valid = 1'b0;
            3'd1, 3'd2: begin  // pointer to a level-0 table
                e.perms.valid      = 1'b1;
                e.perms.readable   = 1'b0;
                e.perms.writable   = 1'b0;
                e.perms.executable = 1'b0;
            end
            3'd3: begin  // aligned leaf as a legal superpage
                e.perms.valid    = 1'b1;
                e.perms.readable = 1'b1;
                e.ppn[9:0]       = '0;
            end
            3'd4: begin
                e.perms.valid    = 1'b1;
                e.perms.writable = 1'b1;
                e.perms.readable = 1'b0;
            end
            default: begin
                e.perms.valid    = 1'b1;
                e.perms.readable = e.perms.readable | ~e.perms.executable;
            end
        endcase
        return e;
    endfunction

    function automatic logic pte_bad(pte_t e);
        return !e.perms.valid || (e.perms.writable && !e.perms.readable);
    endfunction

    function automatic logic pte_leaf(pte_t e);
        return e.perms.readable || e.perms.executable;
    endfunction

    function automatic logic perm_ok(pte_perms_t p, access_t acc, csr_t c);
        logic need;
        need = (acc == INSTRUCTION) ? p.executable : (acc == STORE) ? p.writable : p.readable;
        if (c.priv == U_MODE)
            return need && p.user;
        if (p.user)
            return need && c.sum && acc != INSTRUCTION;  // supervisor on a user page
        return need;
    endfunction

    // reference walk; cached is set when the leaf lands in the buffer
    function automatic void model_xlate(input va_t va, input access_t acc, input csr_t c,
                                        output logic [PADDR_W-1:0] pa, output logic flt,
                                        output logic cached);
        pte_t       l1;
        pte_t       l0;
        logic [9:0] idx;
        pa     = {2'b00, va};
        flt    = 1'b0;
        cached = 1'b0;
        if (!c.trans_en || c.priv == M_MODE)
            return;
        idx = 10'({c.root_ppn, va.vpn1} % MEM_WORDS);
        l1  = pt_image[idx];
        if (pte_bad(l1) || (pte_leaf(l1) && l1.ppn[9:0] != '0)) begin
            flt = 1'b1;
            return;
        end
        if (pte_leaf(l1)) begin
            cached = 1'b1;
            pa     = {l1.ppn[21:10], va.vpn0, va.offset};
            flt    = !perm_ok(l1.perms, acc, c);
            return;
        end
        idx = 10'({l1.ppn, va.vpn0} % MEM_WORDS);
        l0  = pt_image[idx];
        if (pte_bad(l0) || !pte_leaf(l0)) begin
            flt = 1'b1;
            return;
        end
        cached = 1'b1;
        pa     = {l0.ppn, va.offset};
        flt    = !perm_ok(l0.perms, acc, c);
    endfunction

    task automatic end_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    task automatic load_word(input int i, input pte_t w);
        ld_en   = 1'b1;
        ld_addr = 32'(i);
        ld_data = w;
        @(posedge CLK);
        #1;
        ld_en = 1'b0;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
    endtask

    task automatic check_rsp(input int p, input logic exp_flt, input logic [PADDR_W-1:0] exp_pa);
        checks++;
        if (xrsp[p].fault !== exp_flt) begin
            errors++;
            $display("[FAIL] %0t ns xrsp[%0d].fault expected %0b actual %0b",
                     $time, p, exp_flt, xrsp[p].fault);
        end else if (!exp_flt && xrsp[p].paddr !== exp_pa) begin
            errors++;
            $display("[FAIL] %0t ns xrsp[%0d].paddr expected %h actual %h",
                     $time, p, exp_pa, xrsp[p].paddr);
        end
    endtask

    // one request per port in mask with port 0 always fetching
    task automatic xlate(input logic [1:0] mask, input va_t va_i, input va_t va_d,
                         input access_t acc_d, input logic [1:0] want_hit,
                         output logic [1:0] cached);
        logic [PADDR_W-1:0] exp_pa [2];
        logic [1:0]         exp_flt;
        logic [1:0]         pend;
        int                 cyc;
        model_xlate(va_i, INSTRUCTION, csr, exp_pa[0], exp_flt[0], cached[0]);
        model_xlate(va_d, acc_d, csr, exp_pa[1], exp_flt[1], cached[1]);
        cached  = cached & mask;
        if (hung)
            return;  // DUT already stuck
        xreq[0] = '{vaddr: va_i, access: INSTRUCTION};
        xreq[1] = '{vaddr: va_d, access: acc_d};
        req     = mask;
        pend    = mask;
        cyc     = 0;
        while (pend != 2'b00 && cyc < TIMEOUT) begin
            @(posedge CLK);
            #1;
            cyc++;
            for (int p = 0; p < 2; p++) begin
                if (pend[p] && done[p]) begin
                    check_rsp(p, exp_flt[p], exp_pa[p]);
                    if (want_hit[p]) begin
                        checks++;
                        if (cyc != 1) begin
                            errors++;
                            $display("[FAIL] %0t ns done[%0d] latency expected 1 actual %0d",
                                     $time, p, cyc);
                        end
                    end
                    req[p]  = 1'b0;
                    pend[p] = 1'b0;
                end
            end
        end
        @(posedge CLK);  // let the done pulse clear
        #1;
        if (pend != 2'b00) begin
            for (int p = 0; p < 2; p++)
                if (pend[p])
                    $display("timeout: port %0d got no done within %0d cycles", p, TIMEOUT);
            errors++;
            hung = 1'b1;
        end
    endtask

    initial begin : stimulus
        va_t         va_i;
        va_t         va_d;
        logic [31:0] r;
        logic [1:0]  mask;
        logic [1:0]  cached;
        logic [1:0]  unused_cached;
        access_t     acc;
        nRST    = 1'b0;
        flush   = 1'b0;
        req     = 2'b00;
        xreq    = '0;
        csr     = '0;
        ld_en   = 1'b0;
        ld_addr = '0;
        ld_data = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            pt_image[i] = rand_pte();
        // fixed words for the fault and permission cases
        pt_image[1] = pte_t'({22'h2A5400, 10'b00_0000_1111});  // aligned rwx superpage
        pt_image[2] = pte_t'({22'h00C001, 10'b00_0000_0011});  // misaligned superpage
        pt_image[3] = pte_t'({22'h000123, 10'b00_0000_0000});  // invalid
        pt_image[4] = pte_t'({22'h000456, 10'b00_0000_0101});  // W without R
        pt_image[5] = pte_t'({22'h000077, 10'b00_0000_0001});  // pointer
        pt_image[6] = pte_t'({22'h000100, 10'b00_0000_0001});  // pointer
        pt_image[7] = pte_t'({22'h00ABCD, 10'b00_0001_0011});  // user read-only leaf
        repeat (8) @(posedge CLK);
        #1;
        nRST = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++)
            load_word(i, pt_image[i]);

        // pass-through under satp bare and then M-mode
        csr.trans_en = 1'b0;
        csr.priv     = S_MODE;
        for (int k = 0; k < 16; k++) begin
            if (k == 8) begin
                csr.trans_en = 1'b1;
                csr.priv     = M_MODE;
            end
            xlate(2'b11, va_t'(next_rand()), va_t'(next_rand()), LOAD, 2'b00, cached);
        end

        // superpage and structural faults
        csr.priv = S_MODE;
        csr.sum  = 1'b0;
        for (int w = 1; w <= 5; w++) begin
            va_d      = rand_va();
            va_d.vpn1 = 10'(w);
            va_d.vpn0 = 10'd5;  // word 5 holds a pointer again
            xlate(2'b11, va_d, va_d, LOAD, 2'b00, cached);
        end

        // user page under S and U with sum off and on
        va_d      = rand_va();
        va_d.vpn1 = 10'd6;
        va_d.vpn0 = 10'd7;
        for (int k = 0; k < 6; k++) begin
            csr.priv = (k < 4) ? S_MODE : U_MODE;
            csr.sum  = k[0];
            acc      = k[1] ? STORE : LOAD;
            xlate(2'b11, va_d, va_d, acc, 2'b00, cached);
        end

        for (int n = 0; n < 400; n++) begin
            r            = next_rand();
            csr.trans_en = (r[2:0] != 3'd0);
            csr.sum      = r[3];
            case (r[5:4])
                2'd0:    csr.priv = U_MODE;
                2'd3:    csr.priv = M_MODE;
                default: csr.priv = S_MODE;
            endcase
            acc  = r[6] ? STORE : LOAD;
            mask = (r[9:7] == 3'd0) ? 2'b11 : (r[10] ? 2'b10 : 2'b01);
            va_i = rand_va();
            va_d = rand_va();
            xlate(mask, va_i, va_d, acc, 2'b00, cached);
            if (r[11] && cached != 2'b00)  // now resident so it must hit
                xlate(cached, va_i, va_d, acc, cached, unused_cached);
        end

        // remap a resident page, flush, and expect the new mapping
        csr.trans_en = 1'b1;
        csr.priv     = U_MODE;
        va_d         = rand_va();
        va_d.vpn1    = 10'd6;
        va_d.vpn0    = 10'd7;
        xlate(2'b10, va_d, va_d, LOAD, 2'b00, cached);
        xlate(2'b10, va_d, va_d, LOAD, 2'b10, cached);
        pt_image[7].ppn = 22'h0BEEF;
        load_word(7, pt_image[7]);
        pulse_flush();
        xlate(2'b10, va_d, va_d, LOAD, 2'b00, cached);

        end_run();
    end

endmodule

// ==== mmu_top.sv ====
/*
 * mmu top
 * instruction and data translation buffers sharing one page walker and
 * one page table memory
 */
`timescale 1ns/1ps

module mmu_top import mmu_pkg::*; #(
    parameter int TLB_ENTRIES   = 4,
    parameter int PTE_MEM_WORDS = 1024,
    parameter int MEM_LATENCY   = 2
) (
    input  logic               CLK,
    input  logic               nRST,
    input  csr_t               csr,
    input  logic               flush,
    input  logic [1:0]         req,     // 0 = instruction, 1 = data
    input  xlat_req_t [1:0]    xreq,
    output logic [1:0]         done,
    output xlat_rsp_t [1:0]    xrsp,
    input  logic               ld_en,
    input  logic [PADDR_W-3:0] ld_addr,
    input  pte_t               ld_data
);

    logic [1:0]         miss;
    walk_req_t [1:0]    wreq;
    logic [1:0]         walk_done;
    walk_rsp_t          wrsp;
    logic               rd_en;
    logic [PADDR_W-3:0] rd_addr;
    logic               rd_valid;
    pte_t               rd_data;

    for (genvar p = 0; p < 2; p++) begin : g_tlb
        tlb #(
            .TLB_ENTRIES (TLB_ENTRIES),
            .PORT_ID     (1'(p))
        ) tlb_inst (
            .CLK       (CLK),
            .nRST      (nRST),
            .csr       (csr),
            .flush     (flush),
            .req       (req[p]),
            .xreq      (xreq[p]),
            .done      (done[p]),
            .xrsp      (xrsp[p]),
            .miss      (miss[p]),
            .wreq      (wreq[p]),
            .walk_done (walk_done[p]),
            .wrsp      (wrsp)
        );
    end

    page_walker page_walker_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .csr       (csr),
        .miss      (miss),
        .wreq      (wreq),
        .walk_done (walk_done),
        .wrsp      (wrsp),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    pte_mem #(
        .PTE_MEM_WORDS (PTE_MEM_WORDS),
        .MEM_LATENCY   (MEM_LATENCY)
    ) pte_mem_inst (
        .CLK      (CLK),
        .nRST     (nRST),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .ld_en    (ld_en),
        .ld_addr  (ld_addr),
        .ld_data  (ld_data)
    );

endmodule

// ==== pte_mem.sv ====
/*
 * pte memory
 * page table word store with a fixed read latency and a load port for setup
 */
`timescale 1ns/1ps

module pte_mem import mmu_pkg::*; #(
    parameter int PTE_MEM_WORDS = 1024,
    parameter int MEM_LATENCY   = 2
) (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               rd_en,
    input  logic [PADDR_W-3:0] rd_addr,
    output logic               rd_valid,
    output pte_t               rd_data,
    input  logic               ld_en,
    input  logic [PADDR_W-3:0] ld_addr,
    input  pte_t               ld_data
);

    localparam int AW = (PTE_MEM_WORDS > 1) ? $clog2(PTE_MEM_WORDS) : 1;

    pte_t             mem [PTE_MEM_WORDS];
    pte_t             data_pipe [MEM_LATENCY];
    logic [MEM_LATENCY-1:0] vld_pipe;
    logic [AW-1:0]    rd_idx;
    logic [AW-1:0]    ld_idx;

    // word address wraps onto the array
    assign rd_idx = AW'(rd_addr % PTE_MEM_WORDS);
    assign ld_idx = AW'(ld_addr % PTE_MEM_WORDS);

    always_ff @(posedge CLK) begin
        if (ld_en)
            mem[ld_idx] <= ld_data;
        data_pipe[0] <= mem[rd_idx];
        for (int i = 1; i < MEM_LATENCY; i++)
            data_pipe[i] <= data_pipe[i-1];
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= rd_en;
            for (int i = 1; i < MEM_LATENCY; i++)
                vld_pipe[i] <= vld_pipe[i-1];
        end
    end

    assign rd_valid = vld_pipe[MEM_LATENCY-1];
    assign rd_data  = data_pipe[MEM_LATENCY-1];

endmodule

// ==== page_walker.sv ====
/*
 * page walker
 * shared two-level Sv32 walk for both translation buffers, data miss first;
 * reads PTEs from the page table memory and returns a leaf or a fault
 */
`timescale 1ns/1ps

module page_walker import mmu_pkg::*; (
    input  logic               CLK,
    input  logic               nRST,
    input  csr_t               csr,
    input  logic [1:0]         miss,
    input  walk_req_t [1:0]    wreq,
    output logic [1:0]         walk_done,
    output walk_rsp_t          wrsp,
    output logic               rd_en,
    output logic [PADDR_W-3:0] rd_addr,
    input  logic               rd_valid,
    input  pte_t               rd_data
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT
    } walk_state_t;

    walk_state_t state;
    walk_req_t   cur;         // request being walked
    logic        top_level;   // reading the level-1 entry
    logic [21:0] next_ppn;    // level-0 table base
    logic        pte_bad;
    logic        pte_leaf;
    logic        finish;
    logic        walk_fault;

    // invalid, or writable without readable
    assign pte_bad  = !rd_data.perms.valid ||
                      (rd_data.perms.writable && !rd_data.perms.readable);
    assign pte_leaf = rd_data.perms.readable || rd_data.perms.executable;

    always_comb begin
        finish     = 1'b0;
        walk_fault = 1'b0;
        if (state == WAIT && rd_valid) begin
            if (pte_bad) begin
                finish     = 1'b1;
                walk_fault = 1'b1;
            end else if (pte_leaf) begin
                finish     = 1'b1;
                walk_fault = top_level && (|rd_data.ppn[9:0]);  // misaligned superpage
            end else if (!top_level) begin
                // pointer where a leaf must be
                finish     = 1'b1;
                walk_fault = 1'b1;
            end
        end
    end

    assign walk_done = finish ? (2'b01 << cur.port) : 2'b00;
    assign wrsp      = '{pte: rd_data, superpage: top_level, fault: walk_fault};

    assign rd_en   = (state == READ);
    assign rd_addr = top_level ? {csr.root_ppn, cur.vpn1} : {next_ppn, cur.vpn0};

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (|miss)
                        state <= READ;
                end
                READ: state <= WAIT;
                WAIT: begin
                    if (rd_valid)
                        state <= finish ? IDLE : READ;  // pointer goes one level down
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && |miss) begin
            cur       <= miss[1] ? wreq[1] : wreq[0];  // fixed priority, data port wins
            top_level <= 1'b1;
        end
        if (state == WAIT && rd_valid && !finish) begin
            next_ppn  <= rd_data.ppn;
            top_level <= 1'b0;
        end
    end

endmodule

// ==== tlb.sv ====
/*
 * tlb
 * fully associative translation buffer for one core port; hits answer in a
 * cycle, misses go to the shared page walker and refill a round-robin victim
 */
`timescale 1ns/1ps

module tlb import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 4,
    parameter bit PORT_ID     = 1'b0
) (
    input  logic      CLK,
    input  logic      nRST,
    input  csr_t      csr,
    input  logic      flush,
    input  logic      req,
    input  xlat_req_t xreq,
    output logic      done,
    output xlat_rsp_t xrsp,
    output logic      miss,
    output walk_req_t wreq,
    input  logic      walk_done,
    input  walk_rsp_t wrsp
);

    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    typedef struct packed {
        logic [9:0]  vpn1;
        logic [9:0]  vpn0;       // ignored on superpage match
        logic        superpage;
        logic [21:0] ppn;
        pte_perms_t  perms;
    } tlb_entry_t;

    tlb_entry_t             entry [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] entry_vld;
    logic [IDX_W-1:0]       victim;     // round-robin refill pointer
    logic [IDX_W-1:0]       hit_idx;
    tlb_entry_t             hit_entry;
    logic                   hit;
    logic                   xlat_on;
    logic                   accept;
    logic                   refill;
    va_t                    va;

    function automatic logic [PADDR_W-1:0] form_paddr(logic [21:0] ppn, logic superpage,
                                                      va_t vaddr);
        if (superpage)
            return {ppn[21:10], vaddr.vpn0, vaddr.offset};  // 4 MiB page
        return {ppn, vaddr.offset};
    endfunction

    assign va      = xreq.vaddr;
    assign xlat_on = csr.trans_en && (csr.priv != M_MODE);
    assign accept  = req && !done && !miss;  // req still high in the done cycle
    assign refill  = miss && walk_done;

    // lookup, lowest matching index wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entry_vld[i] && entry[i].vpn1 == va.vpn1 &&
                (entry[i].superpage || entry[i].vpn0 == va.vpn0)) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign hit_entry = entry[hit_idx];

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            done      <= 1'b0;
            miss      <= 1'b0;
            entry_vld <= '0;
            victim    <= '0;
        end else begin
            done <= 1'b0;
            if (flush)
                entry_vld <= '0;
            if (accept) begin
                if (!xlat_on || hit)
                    done <= 1'b1;
                else
                    miss <= 1'b1;  // held until the walker answers
            end
            if (refill) begin
                miss <= 1'b0;
                done <= 1'b1;
                if (!wrsp.fault && !flush) begin
                    entry_vld[victim] <= 1'b1;
                    victim <= (victim == IDX_W'(TLB_ENTRIES - 1)) ? '0 : victim + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            xrsp.paddr <= xlat_on ? form_paddr(hit_entry.ppn, hit_entry.superpage, va)
                                  : PADDR_W'(va);
            xrsp.fault <= xlat_on && !access_ok(hit_entry.perms, xreq.access, csr);
            wreq       <= '{vpn1: va.vpn1, vpn0: va.vpn0, port: PORT_ID};
        end
        if (refill) begin
            xrsp.paddr <= form_paddr(wrsp.pte.ppn, wrsp.superpage, va);
            xrsp.fault <= wrsp.fault || !access_ok(wrsp.pte.perms, xreq.access, csr);
            if (!wrsp.fault) begin
                entry[victim] <= '{vpn1:      va.vpn1,
                                   vpn0:      va.vpn0,
                                   superpage: wrsp.superpage,
                                   ppn:       wrsp.pte.ppn,
                                   perms:     wrsp.pte.perms};
            end
        end
    end

endmodule

// ==== mmu_pkg.sv ====
/*
 * mmu package
 * shared Sv32 types for the translation buffers, the page walker and the
 * page table memory, plus the leaf permission check
 */
package mmu_pkg;

    localparam int PADDR_W = 34;  // Sv32 physical address width

    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE,
        INSTRUCTION
    } access_t;

    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        S_MODE = 2'b01,
        M_MODE = 2'b11
    } priv_t;

    typedef struct packed {
        logic [1:0] reserved;  // rsw, software use
        logic       dirty;
        logic       accessed;
        logic       glob;      // G bit
        logic       user;
        logic       executable;
        logic       writable;
        logic       readable;
        logic       valid;
    } pte_perms_t;

    typedef struct packed {
        logic [21:0] ppn;
        pte_perms_t  perms;
    } pte_t;

    typedef struct packed {
        logic [9:0]  vpn1;
        logic [9:0]  vpn0;
        logic [11:0] offset;
    } va_t;

    typedef struct packed {
        va_t     vaddr;
        access_t access;
    } xlat_req_t;

    typedef struct packed {
        logic [PADDR_W-1:0] paddr;
        logic               fault;
    } xlat_rsp_t;

    typedef struct packed {
        logic [9:0] vpn1;
        logic [9:0] vpn0;
        logic       port;  // 0 = instruction, 1 = data
    } walk_req_t;

    typedef struct packed {
        pte_t pte;
        logic superpage;
        logic fault;
    } walk_rsp_t;

    typedef struct packed {
        logic        trans_en;  // satp mode is Sv32
        logic [21:0] root_ppn;
        priv_t       priv;
        logic        sum;
    } csr_t;

    // leaf permission check for one access
    function automatic logic access_ok(pte_perms_t perms, access_t access, csr_t csr);
        logic ok;
        case (access)
            LOAD:        ok = perms.readable;
            STORE:       ok = perms.writable;
            INSTRUCTION: ok = perms.executable;
            default:     ok = 1'b0;
        endcase
        if (csr.priv == U_MODE && !perms.user)
            ok = 1'b0;
        // supervisor may touch user pages only with sum, and never fetch from them
        if (csr.priv == S_MODE && perms.user && (!csr.sum || access == INSTRUCTION))
            ok = 1'b0;
        return ok;
    endfunction

endpackage
